/* common/rvPkg.sv */
package rvPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	// Low three bits follow funct3, bit 3 picks SUB or SRA
	typedef enum logic [3:0]
	{
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_BEQ  = 4'b1001,
		ALU_BNE  = 4'b1010,
		ALU_BLT  = 4'b1011,
		ALU_BGE  = 4'b1100,
		ALU_SRA  = 4'b1101,
		ALU_BLTU = 4'b1110,
		ALU_BGEU = 4'b1111
	} aluOpT;

	typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} uStateT;

	typedef enum logic [1:0] {SEQ, JUMP, JUMPREG, BRANCH} pcSrcT;

	typedef enum logic [1:0] {LINK, MEMDATA, ALURESULT} wbSrcT;

	// Major opcodes
	localparam logic [6:0] opcJal    = 7'b1101111;
	localparam logic [6:0] opcJalr   = 7'b1100111;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcLoad   = 7'b0000011;
	localparam logic [6:0] opcStore  = 7'b0100011;
	localparam logic [6:0] opcOpImm  = 7'b0010011;
	localparam logic [6:0] opcOp     = 7'b0110011;

endpackage

/* common/ctrlIf.sv */
interface ctrlIf import rvPkg::*; ();

	logic pcWrite;
	logic irWrite; // Read data strobe, IR or MDR by iOrD
	logic regWrite;
	logic iOrD;
	logic memWrite;
	logic aluSrcA; // 0 old PC, 1 rs1
	logic aluSrcB; // 0 rs2, 1 immediate
	aluOpT aluOp;
	pcSrcT pcSrc;
	wbSrcT wbSrc;

	wordT instr;
	logic branchTaken;

	modport controller
	(
		output pcWrite, irWrite, regWrite, iOrD, memWrite,
		output aluSrcA, aluSrcB, aluOp, pcSrc, wbSrc,
		input instr, branchTaken
	);

	modport datapath
	(
		input pcWrite, irWrite, regWrite, iOrD, memWrite,
		input aluSrcA, aluSrcB, aluOp, pcSrc, wbSrc,
		output instr, branchTaken
	);

endinterface

/* control/microControl.sv */
module microControl import rvPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic memAck,
	output logic memReq,
	ctrlIf.controller ctrl,
	output logic instRetired
);

	uStateT state;
	uStateT nextState;
	logic ackSeen; // Ack came, waiting for it to drop
	logic memPhase;
	logic memDone;
	logic [6:0] opcode;
	logic [2:0] funct3;

	assign opcode = ctrl.instr[6:0];
	assign funct3 = ctrl.instr[14:12];
	assign memPhase = (state == FETCH) || (state == MEMORY);
	assign memDone = ackSeen && !memAck; // Four-phase cycle closed

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state <= FETCH;
		else
			state <= nextState;
	end

	// Request side of the four-phase handshake
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			memReq <= 1'b0;
			ackSeen <= 1'b0;
		end
		else if (memPhase)
		begin
			if (memReq && memAck)
			begin
				memReq <= 1'b0;
				ackSeen <= 1'b1;
			end
			else if (memDone)
				ackSeen <= 1'b0;
			else if (!memReq && !ackSeen && !memAck)
				memReq <= 1'b1; // Previous ack is low
		end
	end

	always_comb
	begin
		nextState = state;
		instRetired = 1'b0;
		ctrl.pcWrite = 1'b0;
		ctrl.irWrite = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.iOrD = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.aluSrcA = 1'b1;
		ctrl.aluSrcB = 1'b1;
		ctrl.aluOp = ALU_ADD;
		ctrl.pcSrc = SEQ;
		ctrl.wbSrc = ALURESULT;
		case (state)
			FETCH:
			begin
				ctrl.irWrite = memReq && memAck; // Word valid with ack
				if (memDone)
				begin
					ctrl.pcWrite = 1'b1; // PC + 4
					nextState = DECODE;
				end
			end
			DECODE:
			begin
				case (opcode)
					opcJal, opcJalr, opcBranch, opcLoad, opcStore, opcOpImm, opcOp:
						nextState = EXECUTE;
					default:
						nextState = FETCH; // Unknown, dropped without retire
				endcase
			end
			EXECUTE:
			begin
				nextState = WRITEBACK;
				case (opcode)
					opcJal:
					begin
						ctrl.aluSrcA = 1'b0; // Old PC + imm
						ctrl.pcWrite = 1'b1;
						ctrl.pcSrc = JUMP;
					end
					opcJalr:
					begin
						ctrl.pcWrite = 1'b1;
						ctrl.pcSrc = JUMPREG;
					end
					opcBranch:
					begin
						ctrl.aluSrcB = 1'b0;
						case (funct3)
							3'b000: ctrl.aluOp = ALU_BEQ;
							3'b001: ctrl.aluOp = ALU_BNE;
							3'b100: ctrl.aluOp = ALU_BLT;
							3'b101: ctrl.aluOp = ALU_BGE;
							3'b110: ctrl.aluOp = ALU_BLTU;
							3'b111: ctrl.aluOp = ALU_BGEU;
							default: ctrl.aluOp = ALU_ADD; // Never taken
						endcase
						ctrl.pcSrc = BRANCH;
						ctrl.pcWrite = ctrl.branchTaken;
						instRetired = 1'b1;
						nextState = FETCH;
					end
					opcLoad, opcStore:
						nextState = MEMORY; // Address is rs1 + imm
					opcOpImm:
						ctrl.aluOp = aluOpT'({funct3 == 3'b101 && ctrl.instr[30], funct3});
					opcOp:
					begin
						ctrl.aluSrcB = 1'b0;
						ctrl.aluOp = aluOpT'({ctrl.instr[30], funct3});
					end
					default:
						nextState = FETCH;
				endcase
			end
			MEMORY:
			begin
				ctrl.iOrD = 1'b1;
				ctrl.memWrite = (opcode == opcStore); // Any funct3 stores a word
				ctrl.irWrite = memReq && memAck && (opcode != opcStore);
				if (memDone)
				begin
					if (opcode == opcStore)
					begin
						instRetired = 1'b1;
						nextState = FETCH;
					end
					else
						nextState = WRITEBACK;
				end
			end
			WRITEBACK:
			begin
				ctrl.regWrite = 1'b1;
				if (opcode == opcJal || opcode == opcJalr)
					ctrl.wbSrc = LINK;
				else if (opcode == opcLoad)
					ctrl.wbSrc = MEMDATA;
				instRetired = 1'b1;
				nextState = FETCH;
			end
			default:
				nextState = FETCH;
		endcase
	end

endmodule

/* design/aluUnit.sv */
module aluUnit import rvPkg::*;
(
	input wordT a,
	input wordT b,
	input aluOpT op,
	output wordT result,
	output logic branchTaken
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb
	begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: result = {31'b0, a < b};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt; // Sign fill
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0; // Branch codes only compare
		endcase
	end

	// Branch condition on rs1 and rs2
	always_comb
	begin
		case (op)
			ALU_BEQ:  branchTaken = (a == b);
			ALU_BNE:  branchTaken = (a != b);
			ALU_BLT:  branchTaken = ($signed(a) < $signed(b));
			ALU_BGE:  branchTaken = ($signed(a) >= $signed(b));
			ALU_BLTU: branchTaken = (a < b);
			ALU_BGEU: branchTaken = (a >= b);
			default:  branchTaken = 1'b0;
		endcase
	end

endmodule

/* design/regFile.sv */
module regFile import rvPkg::*;
(
	input logic clk,
	input logic rstN,
	input regAddrT rs1,
	input regAddrT rs2,
	input regAddrT rd,
	input wordT wdata,
	input logic we,
	output wordT rdata1,
	output wordT rdata2
);

	wordT regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && rd != 5'd0)
			regs[rd] <= wdata;
	end

	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* design/multiCycleDatapath.sv */
module multiCycleDatapath import rvPkg::*;
#(
	parameter wordT resetPc = '0
)
(
	input logic clk,
	input logic rstN,
	ctrlIf.datapath ctrl,
	input wordT memRdata,
	output wordT memAddr,
	output wordT memWdata,
	output logic [3:0] memBe,
	output wordT instCount,
	input logic instRetired
);

	wordT pc, oldPc, ir, mdr;
	wordT regA, regB, aluOut; // Latched every cycle
	wordT rdata1, rdata2;
	wordT imm, aluA, aluB, aluResult;
	wordT nextPc, wbData;
	logic taken;

	assign ctrl.instr = ir;
	assign ctrl.branchTaken = taken;

	regFile rf
	(
		.clk(clk),
		.rstN(rstN),
		.rs1(ir[19:15]),
		.rs2(ir[24:20]),
		.rd(ir[11:7]),
		.wdata(wbData),
		.we(ctrl.regWrite),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	// Immediate format follows the opcode
	always_comb
	begin
		case (ir[6:0])
			opcStore:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			opcBranch: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			opcJal:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			default:   imm = {{20{ir[31]}}, ir[31:20]};
		endcase
	end

	assign aluA = ctrl.aluSrcA ? regA : oldPc;
	assign aluB = ctrl.aluSrcB ? imm : regB;

	aluUnit alu
	(
		.a(aluA),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.branchTaken(taken)
	);

	always_comb
	begin
		case (ctrl.pcSrc)
			JUMP:    nextPc = aluResult;
			JUMPREG: nextPc = {aluResult[31:1], 1'b0};
			BRANCH:  nextPc = oldPc + imm; // Only written when taken
			default: nextPc = pc + 32'd4;
		endcase
	end

	always_comb
	begin
		case (ctrl.wbSrc)
			LINK:    wbData = oldPc + 32'd4;
			MEMDATA: wbData = mdr;
			default: wbData = aluOut;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= resetPc;
			oldPc <= resetPc;
			instCount <= '0;
		end
		else
		begin
			if (ctrl.pcWrite)
				pc <= nextPc;
			if (ctrl.irWrite && !ctrl.iOrD)
				oldPc <= pc; // Address of the fetched word
			if (instRetired)
				instCount <= instCount + 32'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.irWrite)
		begin
			if (ctrl.iOrD)
				mdr <= memRdata;
			else
				ir <= memRdata;
		end
		regA <= rdata1;
		regB <= rdata2;
		aluOut <= aluResult;
	end

	assign memAddr = ctrl.iOrD ? aluOut : pc;
	assign memWdata = regB;
	assign memBe = {4{ctrl.memWrite}}; // Word store only

endmodule

/* design/cpuCore.sv */
module cpuCore import rvPkg::*;
#(
	parameter wordT resetPc = '0
)
(
	input logic clk,
	input logic rstN,
	output logic memReq,
	output logic memWe,
	output wordT memAddr,
	output wordT memWdata,
	output logic [3:0] memBe,
	input logic memAck,
	input wordT memRdata,
	output wordT instCount
);

	logic instRetired;

	ctrlIf ctrl();

	microControl uCtrl
	(
		.clk(clk),
		.rstN(rstN),
		.memAck(memAck),
		.memReq(memReq),
		.ctrl(ctrl.controller),
		.instRetired(instRetired)
	);

	multiCycleDatapath #(.resetPc(resetPc)) dPath
	(
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl.datapath),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memBe(memBe),
		.instCount(instCount),
		.instRetired(instRetired)
	);

	assign memWe = ctrl.memWrite;

endmodule

/* testbench/clockGen.sv */
module clockGen
(
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Three cycles of reset, released on a falling edge
	initial
	begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

/* testbench/memHandshake_checker.sv */
module memHandshake_checker import rvPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic memReq,
	input logic memAck,
	input logic memWe,
	input wordT memAddr
);

	int failCount = 0; // Protocol violations seen

	// Request held until the acknowledge arrives
	reqHeld: assert property (@(posedge clk) disable iff (!rstN)
		memReq && !memAck |=> memReq)
		else
		begin
			failCount++;
			$error("memReq dropped before memAck was raised");
		end

	reqStable: assert property (@(posedge clk) disable iff (!rstN)
		memReq && !memAck |=> $stable(memAddr) && $stable(memWe))
		else
		begin
			failCount++;
			$error("Address or write enable changed during a pending request");
		end

	// New request only after the previous ack went low
	reqRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(memReq) |-> !$past(memAck))
		else
		begin
			failCount++;
			$error("memReq raised while memAck was still high");
		end

endmodule

/* testbench/cpuTb.sv */
module cpuTb import rvPkg::*;
();

	localparam int nProg = 76;
	localparam int nExp = 29;
	localparam int expCount = 67; // Instructions retired before the final fetch

	logic clk;
	logic rstN;
	logic memReq;
	logic memWe;
	wordT memAddr;
	wordT memWdata;
	logic [3:0] memBe;
	logic memAck;
	wordT memRdata;
	wordT instCount;

	wordT mem [256];
	int storeIdx;
	int memErrors;
	int runErrors;

	// Program words from address zero
	wordT progTable [nProg] = '{
		32'hFEC00093, // addi x1, x0, -20
		32'h00700113, // addi x2, x0, 7
		32'h20000193, // addi x3, x0, 0x200
		32'h00208233, // add
		32'h0041A023,
		32'h40208233, // sub
		32'h0041A223,
		32'h00209233, // sll
		32'h0041A423,
		32'h0020A233, // slt
		32'h0041A623,
		32'h0020B233, // sltu
		32'h0041A823,
		32'h0020C233, // xor
		32'h0041AA23,
		32'h0020D233, // srl
		32'h0041AC23,
		32'h4020D233, // sra
		32'h0041AE23,
		32'h0020E233, // or
		32'h0241A023,
		32'h0020F233, // and
		32'h0241A223,
		32'h06408213, // addi x4, x1, 100
		32'h0241A423,
		32'hFED0A213, // slti x4, x1, -19
		32'h0241A623,
		32'hFFF13213, // sltiu x4, x2, -1
		32'h0241A823,
		32'h0F00C213, // xori x4, x1, 0xF0
		32'h0241AA23,
		32'h70016213, // ori x4, x2, 0x700
		32'h0241AC23,
		32'h0FF0F213, // andi x4, x1, 0xFF
		32'h0241AE23,
		32'h01411213, // slli x4, x2, 20
		32'h0441A023,
		32'h0040D213, // srli x4, x1, 4
		32'h0441A223,
		32'h4020D213, // srai x4, x1, 2
		32'h0441A423,
		32'h0001A283, // lw x5, 0(x3)
		32'h0451A823, // sw x5, 80(x3)
		// Not taken runs a marker store and taken skips a bad store
		32'h00208463, // beq x1, x2
		32'h0621A023,
		32'h00108463, // beq x1, x1
		32'h0E11A823,
		32'h00109463, // bne x1, x1
		32'h0621A223,
		32'h00209463, // bne x1, x2
		32'h0E11A823,
		32'h00114463, // blt x2, x1
		32'h0621A423,
		32'h0020C463, // blt x1, x2
		32'h0E11A823,
		32'h0020D463, // bge x1, x2
		32'h0621A623,
		32'h00115463, // bge x2, x1
		32'h0E11A823,
		32'h0020E463, // bltu x1, x2
		32'h0621A823,
		32'h00116463, // bltu x2, x1
		32'h0E11A823,
		32'h00117463, // bgeu x2, x1
		32'h0621AA23,
		32'h0020F463, // bgeu x1, x2
		32'h0E11A823,
		32'h0080036F, // jal x6, +8
		32'h0E11A823,
		32'h0661AC23, // sw x6, 0x78(x3)
		32'h11F00393, // addi x7, x0, 0x11F
		32'h00638467, // jalr x8, 6(x7) lands on 0x124
		32'h0E11A823,
		32'h0681AE23, // sw x8, 0x7C(x3)
		32'h0821A023,
		32'h0000006F // jal x0, 0
	};

	// Expected stores in order with the address in the upper half
	logic [63:0] expStore [nExp] = '{
		64'h00000200_FFFFFFF3,
		64'h00000204_FFFFFFE5,
		64'h00000208_FFFFF600,
		64'h0000020C_00000001,
		64'h00000210_00000000,
		64'h00000214_FFFFFFEB,
		64'h00000218_01FFFFFF,
		64'h0000021C_FFFFFFFF, // sra keeps the sign
		64'h00000220_FFFFFFEF,
		64'h00000224_00000004,
		64'h00000228_00000050,
		64'h0000022C_00000001,
		64'h00000230_00000001,
		64'h00000234_FFFFFF1C,
		64'h00000238_00000707,
		64'h0000023C_000000EC,
		64'h00000240_00700000,
		64'h00000244_0FFFFFFE,
		64'h00000248_FFFFFFFB,
		64'h00000250_FFFFFFF3, // Load of the add result
		64'h00000260_00000007,
		64'h00000264_00000007,
		64'h00000268_00000007,
		64'h0000026C_00000007,
		64'h00000270_00000007,
		64'h00000274_00000007,
		64'h00000278_00000110, // jal link
		64'h0000027C_00000120, // jalr link
		64'h00000280_00000007
	};

	clockGen clkGen
	(
		.clk(clk),
		.rstN(rstN)
	);

	cpuCore #(.resetPc(32'h0)) UUT
	(
		.clk(clk),
		.rstN(rstN),
		.memReq(memReq),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memBe(memBe),
		.memAck(memAck),
		.memRdata(memRdata),
		.instCount(instCount)
	);

	bind cpuCore memHandshake_checker hsCheck
	(
		.clk(clk),
		.rstN(rstN),
		.memReq(memReq),
		.memAck(memAck),
		.memWe(memWe),
		.memAddr(memAddr)
	);

	task automatic checkStore();
		logic [63:0] row;
		assert (storeIdx < nExp)
		else
		begin
			memErrors++;
			$display("Store to %h beyond the expected list at time %0t", memAddr, $time);
		end
		if (storeIdx < nExp)
		begin
			row = expStore[storeIdx];
			assert (memAddr == row[63:32] && memWdata == row[31:0] && memBe == 4'hF)
			else
			begin
				memErrors++;
				$display("[FAIL] %0t store %0d got %h <= %h be %b, expected %h <= %h",
					$time, storeIdx, memAddr, memWdata, memBe, row[63:32], row[31:0]);
			end
			storeIdx++;
		end
		mem[memAddr[9:2]] = memWdata;
	endtask

	task automatic readWord();
		assert (memAddr[1:0] == 2'b00)
		else
		begin
			memErrors++;
			$display("Read from unaligned address %h at time %0t", memAddr, $time);
		end
		memRdata = mem[memAddr[9:2]];
	endtask

	// Memory model acks each request after 0 to 3 cycles
	initial
	begin
		int ackWait;
		void'($urandom(51881));
		ackWait = -1;
		memAck = 1'b0;
		memRdata = '0;
		storeIdx = 0;
		memErrors = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hBAD00000 ^ (i << 2);
		for (int i = 0; i < nProg; i++)
			mem[i] = progTable[i];
		forever
		begin
			@(negedge clk);
			if (memReq && !memAck)
			begin
				if (ackWait < 0)
					ackWait = int'($urandom % 4);
				if (ackWait == 0)
				begin
					if (memWe)
						checkStore();
					else
						readWord();
					memAck = 1'b1;
					ackWait = -1;
				end
				else
					ackWait--;
			end
			else if (!memReq && memAck)
				memAck = 1'b0; // Request dropped so the cycle closes
		end
	end

	initial
	begin
		runErrors = 0;
		@(negedge clk);
		assert (memReq == 1'b0 && instCount == 32'd0)
		else
		begin
			runErrors++;
			$display("[FAIL] %0t reset state memReq %b instCount %0d", $time, memReq, instCount);
		end
		wait (storeIdx == nExp);
		// Next fetch request means the last store has retired
		while (!(memReq && !memWe))
			@(negedge clk);
		assert (instCount == expCount)
		else
		begin
			runErrors++;
			$display("[FAIL] %0t instCount %0d, expected %0d", $time, instCount, expCount);
		end
		$display("Errors: memory side %0d, core state %0d, handshake %0d",
			memErrors, runErrors, UUT.hsCheck.failCount);
		if (memErrors == 0 && runErrors == 0 && UUT.hsCheck.failCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		repeat (nProg * 60 + 200) @(posedge clk);
		$display("Timeout after %0d cycles, program did not finish", nProg * 60 + 200);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* rvMulticycle.f */
common/rvPkg.sv
common/ctrlIf.sv
control/microControl.sv
design/aluUnit.sv
design/regFile.sv
design/multiCycleDatapath.sv
design/cpuCore.sv
testbench/clockGen.sv
testbench/memHandshake_checker.sv
testbench/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module cpuTb -Mdir obj_dir -f rvMulticycle.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VcpuTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
	echo "No pass message in sim.log"
	exit 1
fi
exit 0
